//--- hdl/iq_macros.svh
// Instruction queue geometry
`ifndef IQ_MACROS_SVH
`define IQ_MACROS_SVH

// Payload field widths
`define INSN_W 32
`define PC_W 32
`define EXC_W 2
`define BPU_UPD_W 8

// Log2 of fetch window slots
`define P_FETCH_W 2
// Log2 of decode issue slots
`define P_ISSUE_W 1
// Log2 of entries held per bank
`define P_BANK_DEPTH 2

// Slot counts derived from the log2 values
`define FETCH_W (1 << `P_FETCH_W)
`define ISSUE_W (1 << `P_ISSUE_W)

// Byte offset bits inside one instruction word
`define WORD_OFS_W 2

`endif

//--- hdl/fetch_pkg.sv
// Fetch payload types
`include "iq_macros.svh"

package fetch_pkg;

   // Raw instruction word
   typedef logic [`INSN_W-1:0] insn_t;

   // Instruction address
   typedef logic [`PC_W-1:0] pc_t;

   // Front-end exception code, carried untouched
   typedef logic [`EXC_W-1:0] exc_t;

   // Predictor update tag, carried untouched
   typedef logic [`BPU_UPD_W-1:0] bpu_upd_t;

   // One queue entry
   // Field order fixes the packed layout inside each bank
   typedef struct packed
   {
      insn_t    ins;
      pc_t      pc;
      exc_t     exc;
      bpu_upd_t bpu_upd;
   } iq_entry_t;

endpackage

//--- hdl/bank_pkg.sv
// Bank index and count types
`include "iq_macros.svh"

package bank_pkg;

   // Bank select, also a window slot select
   typedef logic [`P_FETCH_W-1:0] bank_idx_t;

   // Push count 0..FETCH_W, one extra bit for the full window
   typedef logic [`P_FETCH_W:0] push_cnt_t;

   // Pop count 0..ISSUE_W
   typedef logic [`P_ISSUE_W:0] pop_cnt_t;

endpackage

//--- hdl/fifo_fwft.sv
// First-word-fall-through bank FIFO
`timescale 1ns/1ps
`include "iq_macros.svh"

module fifo_fwft
   import fetch_pkg::*;
#(
   parameter int DEPTH_P = `P_BANK_DEPTH
)
(
   input  logic      clk,
   input  logic      rst_n,
   input  logic      flush,
   input  logic      push,
   input  iq_entry_t din,
   output logic      ready,
   input  logic      pop,
   output iq_entry_t dout,
   output logic      valid
);
   localparam int DEPTH = 1 << DEPTH_P;

   // Storage, no reset needed
   iq_entry_t          mem [DEPTH];
   logic [DEPTH_P-1:0] rd_ptr;
   logic [DEPTH_P-1:0] wr_ptr;
   // One extra bit so a full buffer is distinct from empty
   logic [DEPTH_P:0]   count;
   logic               push_en;
   logic               pop_en;

   // Full exactly when the top count bit is set
   assign ready = ~count[DEPTH_P];
   assign valid = |count;

   // Flush drops any push or pop of the same cycle
   assign push_en = push & ready & ~flush;
   assign pop_en  = pop & valid & ~flush;

   // Head entry falls through to the output
   assign dout = mem[rd_ptr];

   always_ff @(posedge clk)
   begin
      if (push_en)
         mem[wr_ptr] <= din;
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= '0;
      end
      else if (flush)
      begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         // Pointers wrap by natural overflow
         if (push_en)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop_en)
            rd_ptr <= rd_ptr + 1'b1;
         // Occupancy, unchanged on push plus pop
         case ({push_en, pop_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

//--- hdl/fetch_window_align.sv
// Fetch window alignment
`timescale 1ns/1ps
`include "iq_macros.svh"

module fetch_window_align
   import fetch_pkg::*;
   import bank_pkg::*;
(
   input  logic      fetch_valid,
   input  pc_t       fetch_pc,
   input  insn_t     fetch_ins [`FETCH_W],
   input  exc_t      fetch_exc [`FETCH_W],
   input  bpu_upd_t  fetch_bpu_upd [`FETCH_W],
   input  logic      iq_ready,
   output iq_entry_t iq_entries [`FETCH_W],
   output push_cnt_t iq_push_cnt,
   output bank_idx_t iq_push_offset
);
   // Low address bits covering the whole window
   localparam int WIN_LSB = `P_FETCH_W + `WORD_OFS_W;
   localparam push_cnt_t FULL_CNT = push_cnt_t'(`FETCH_W);

   pc_t       win_base;
   push_cnt_t live_cnt;
   logic      take;

   // Window base, low bits cleared
   assign win_base = {fetch_pc[`PC_W-1:WIN_LSB], {WIN_LSB{1'b0}}};

   // Word offset sits just above the byte offset
   assign iq_push_offset = fetch_pc[WIN_LSB-1:`WORD_OFS_W];

   // Slots from the offset upward are live
   assign live_cnt = FULL_CNT - push_cnt_t'(iq_push_offset);

   // Only gating point for the push
   assign take        = fetch_valid & iq_ready;
   assign iq_push_cnt = take ? live_cnt : '0;

   // Each slot PC is base plus four per slot
   // Dead slots are still built, the buffer skips them
   for (genvar i = 0; i < `FETCH_W; i++)
   begin : gen_slot
      assign iq_entries[i].ins     = fetch_ins[i];
      assign iq_entries[i].pc      = win_base + pc_t'(i << `WORD_OFS_W);
      assign iq_entries[i].exc     = fetch_exc[i];
      assign iq_entries[i].bpu_upd = fetch_bpu_upd[i];
   end

endmodule

//--- hdl/prefetch_buf.sv
// Banked prefetch instruction queue
`timescale 1ns/1ps
`include "iq_macros.svh"

module prefetch_buf
   import fetch_pkg::*;
   import bank_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   input  logic      flush,
   // From window alignment
   input  iq_entry_t iq_entries [`FETCH_W],
   input  push_cnt_t iq_push_cnt,
   input  bank_idx_t iq_push_offset,
   output logic      iq_ready,
   // To decode
   output logic [`ISSUE_W-1:0] id_valid,
   input  pop_cnt_t  id_pop_cnt,
   output insn_t     id_ins [`ISSUE_W],
   output pc_t       id_pc [`ISSUE_W],
   output exc_t      id_exc [`ISSUE_W],
   output bpu_upd_t  id_bpu_upd [`ISSUE_W]
);
   localparam int BANKS = `FETCH_W;

   // Rotating pointers, bank of oldest entry and next free bank
   bank_idx_t        head_q;
   bank_idx_t        tail_q;

   iq_entry_t        que_din [BANKS];
   iq_entry_t        que_dout [BANKS];
   logic [BANKS-1:0] que_push;
   logic [BANKS-1:0] que_pop;
   logic [BANKS-1:0] que_valid;
   logic [BANKS-1:0] que_ready;
   // Pop count widened to compare against bank distances
   push_cnt_t        pop_cnt_ext;

   assign pop_cnt_ext = push_cnt_t'(id_pop_cnt);

   // Any window fits while every bank has room
   assign iq_ready = &que_ready;

   for (genvar b = 0; b < BANKS; b++)
   begin : gen_bank
      bank_idx_t tail_dist;
      bank_idx_t head_dist;
      bank_idx_t slot_sel;

      // Distance of this bank past tail and head, modulo bank count
      assign tail_dist = bank_idx_t'(b) - tail_q;
      assign head_dist = bank_idx_t'(b) - head_q;

      // Rotate so the first live slot lands on the tail bank
      assign slot_sel = tail_dist + iq_push_offset;
      assign que_din[b] = iq_entries[slot_sel];

      // Push the first push_cnt banks from tail
      assign que_push[b] = ({1'b0, tail_dist} < iq_push_cnt);
      // Pop the first pop_cnt banks from head
      assign que_pop[b]  = ({1'b0, head_dist} < pop_cnt_ext);

      fifo_fwft #(
         .DEPTH_P (`P_BANK_DEPTH)
      ) u_fifo (
         .clk   (clk),
         .rst_n (rst_n),
         .flush (flush),
         .push  (que_push[b]),
         .din   (que_din[b]),
         .ready (que_ready[b]),
         .pop   (que_pop[b]),
         .dout  (que_dout[b]),
         .valid (que_valid[b])
      );
   end

   // Decode slot j reads the bank at head plus j
   // Round-robin filling keeps id_valid a prefix
   for (genvar j = 0; j < `ISSUE_W; j++)
   begin : gen_issue
      bank_idx_t rd_bank;

      assign rd_bank       = head_q + bank_idx_t'(j);
      assign id_valid[j]   = que_valid[rd_bank];
      assign id_ins[j]     = que_dout[rd_bank].ins;
      assign id_pc[j]      = que_dout[rd_bank].pc;
      assign id_exc[j]     = que_dout[rd_bank].exc;
      assign id_bpu_upd[j] = que_dout[rd_bank].bpu_upd;
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         head_q <= '0;
         tail_q <= '0;
      end
      else if (flush)
      begin
         // Banks empty in the same edge
         head_q <= '0;
         tail_q <= '0;
      end
      else
      begin
         // Truncation gives the wrap modulo four
         head_q <= head_q + bank_idx_t'(id_pop_cnt);
         tail_q <= tail_q + bank_idx_t'(iq_push_cnt);
      end
   end

endmodule

//--- hdl/insn_queue_top.sv
// Instruction queue top level
`timescale 1ns/1ps
`include "iq_macros.svh"

module insn_queue_top
   import fetch_pkg::*;
   import bank_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   input  logic      flush,
   // Fetch side
   input  logic      fetch_valid,
   input  pc_t       fetch_pc,
   input  insn_t     fetch_ins [`FETCH_W],
   input  exc_t      fetch_exc [`FETCH_W],
   input  bpu_upd_t  fetch_bpu_upd [`FETCH_W],
   output logic      fetch_ready,
   // Decode side
   output logic [`ISSUE_W-1:0] id_valid,
   output insn_t     id_ins [`ISSUE_W],
   output pc_t       id_pc [`ISSUE_W],
   output exc_t      id_exc [`ISSUE_W],
   output bpu_upd_t  id_bpu_upd [`ISSUE_W],
   input  pop_cnt_t  id_pop_cnt
);
   // Aligned window into the buffer
   iq_entry_t iq_entries [`FETCH_W];
   push_cnt_t iq_push_cnt;
   bank_idx_t iq_push_offset;

   // Combinational slot PCs and push count
   // Buffer ready doubles as fetch_ready
   fetch_window_align u_align (
      .fetch_valid    (fetch_valid),
      .fetch_pc       (fetch_pc),
      .fetch_ins      (fetch_ins),
      .fetch_exc      (fetch_exc),
      .fetch_bpu_upd  (fetch_bpu_upd),
      .iq_ready       (fetch_ready),
      .iq_entries     (iq_entries),
      .iq_push_cnt    (iq_push_cnt),
      .iq_push_offset (iq_push_offset)
   );

   // Four banks with rotating head and tail
   prefetch_buf u_pbuf (
      .clk            (clk),
      .rst_n          (rst_n),
      .flush          (flush),
      .iq_entries     (iq_entries),
      .iq_push_cnt    (iq_push_cnt),
      .iq_push_offset (iq_push_offset),
      .iq_ready       (fetch_ready),
      .id_valid       (id_valid),
      .id_pop_cnt     (id_pop_cnt),
      .id_ins         (id_ins),
      .id_pc          (id_pc),
      .id_exc         (id_exc),
      .id_bpu_upd     (id_bpu_upd)
   );

endmodule

//--- tests/tb_insn_queue.sv
// Instruction queue testbench
`timescale 1ns/1ps
`include "iq_macros.svh"

module tb_insn_queue
   import fetch_pkg::*;
   import bank_pkg::*;
();
   // Byte span of one fetch window
   localparam int WIN_LSB     = `P_FETCH_W + `WORD_OFS_W;
   localparam int WIN_BYTES   = 1 << WIN_LSB;
   // Total storage over all banks
   localparam int QCAP        = `FETCH_W * (1 << `P_BANK_DEPTH);
   // Round-robin fill puts at most ceil(n/4) entries in any bank
   // Some bank is full once more than this many entries are held
   localparam int READY_LIMIT = QCAP - `FETCH_W;

   logic                clk;
   logic                rst_n;
   logic                flush;
   logic                fetch_valid;
   pc_t                 fetch_pc;
   insn_t               fetch_ins [`FETCH_W];
   exc_t                fetch_exc [`FETCH_W];
   bpu_upd_t            fetch_bpu_upd [`FETCH_W];
   logic                fetch_ready;
   logic [`ISSUE_W-1:0] id_valid;
   insn_t               id_ins [`ISSUE_W];
   pc_t                 id_pc [`ISSUE_W];
   exc_t                id_exc [`ISSUE_W];
   bpu_upd_t            id_bpu_upd [`ISSUE_W];
   pop_cnt_t            id_pop_cnt;

   // Reference queue with the oldest entry at index 0
   iq_entry_t           exp_q [$];
   // Payload of the window on the fetch port
   insn_t               win_ins [`FETCH_W];
   exc_t                win_exc [`FETCH_W];
   bpu_upd_t            win_bpu [`FETCH_W];
   // Decode valids sampled in the last checked cycle
   logic [`ISSUE_W-1:0] valid_seen;
   pc_t                 next_pc;
   integer              seed;
   int                  checks;
   int                  mismatches;
   int                  other_errs;

   insn_queue_top DUT (
      .clk           (clk),
      .rst_n         (rst_n),
      .flush         (flush),
      .fetch_valid   (fetch_valid),
      .fetch_pc      (fetch_pc),
      .fetch_ins     (fetch_ins),
      .fetch_exc     (fetch_exc),
      .fetch_bpu_upd (fetch_bpu_upd),
      .fetch_ready   (fetch_ready),
      .id_valid      (id_valid),
      .id_ins        (id_ins),
      .id_pc         (id_pc),
      .id_exc        (id_exc),
      .id_bpu_upd    (id_bpu_upd),
      .id_pop_cnt    (id_pop_cnt)
   );

   // 40 ns clock
   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // Hard stop if the run goes astray
   initial
   begin
      #200000;
      $display("Simulation stopped by the watchdog before the tests finished");
      $display(">>> FAIL");
      $finish;
   end

   task automatic compare_field(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
      checks++;
      assert (got === exp)
      else
      begin
         $display("MISMATCH at %0t: %s got %0h expected %0h", $time, name, got, exp);
         mismatches++;
      end
   endtask

   // Slot i of the current window as the queue should hold it
   function automatic iq_entry_t expected_slot(input int i, input pc_t pc);
      iq_entry_t e;
      pc_t       base;
      base      = pc & ~pc_t'(WIN_BYTES - 1);
      e.ins     = win_ins[i];
      e.pc      = base + pc_t'(4 * i);
      e.exc     = win_exc[i];
      e.bpu_upd = win_bpu[i];
      return e;
   endfunction

   // Largest pop not above want that decode may legally take
   function automatic int pick_pop(input int want);
      int legal;
      legal = (exp_q.size() < `ISSUE_W) ? exp_q.size() : `ISSUE_W;
      return (want < legal) ? want : legal;
   endfunction

   // Fresh random payload on the fetch port
   task automatic load_window();
      for (int i = 0; i < `FETCH_W; i++)
      begin
         win_ins[i]       = insn_t'($random(seed));
         win_exc[i]       = exc_t'($random(seed));
         win_bpu[i]       = bpu_upd_t'($random(seed));
         fetch_ins[i]     <= win_ins[i];
         fetch_exc[i]     <= win_exc[i];
         fetch_bpu_upd[i] <= win_bpu[i];
      end
   endtask

   // Decode side and ready against the model
   task automatic check_outputs();
      logic [`ISSUE_W-1:0] exp_valid;
      iq_entry_t           e;
      exp_valid = '0;
      for (int j = 0; j < `ISSUE_W; j++)
         exp_valid[j] = (exp_q.size() > j);
      compare_field("id_valid", 64'(id_valid), 64'(exp_valid));
      compare_field("fetch_ready", 64'(fetch_ready), 64'(exp_q.size() <= READY_LIMIT));
      for (int j = 0; j < `ISSUE_W; j++)
      begin
         if (exp_q.size() > j)
         begin
            e = exp_q[j];
            compare_field($sformatf("id_ins[%0d]", j), 64'(id_ins[j]), 64'(e.ins));
            compare_field($sformatf("id_pc[%0d]", j), 64'(id_pc[j]), 64'(e.pc));
            compare_field($sformatf("id_exc[%0d]", j), 64'(id_exc[j]), 64'(e.exc));
            compare_field($sformatf("id_bpu_upd[%0d]", j), 64'(id_bpu_upd[j]),
                          64'(e.bpu_upd));
         end
      end
   endtask

   // One clock of drive, mid-cycle check and model update
   task automatic drive_cycle(input logic fv, input pc_t pc, input int pop,
                              input logic fl, output logic taken);
      int ofs;
      fetch_valid <= fv;
      fetch_pc    <= pc;
      id_pop_cnt  <= pop_cnt_t'(pop);
      flush       <= fl;
      @(negedge clk);
      check_outputs();
      valid_seen = id_valid;
      // Handshake as seen by the fetch side
      taken = fv & fetch_ready;
      @(posedge clk);
      if (fl)
         exp_q.delete();
      else
      begin
         for (int k = 0; k < pop && exp_q.size() > 0; k++)
            void'(exp_q.pop_front());
         if (taken)
         begin
            // Slots below the word offset are dead
            ofs = int'(pc[WIN_LSB-1:`WORD_OFS_W]);
            for (int i = ofs; i < `FETCH_W; i++)
               exp_q.push_back(expected_slot(i, pc));
         end
      end
      assert (exp_q.size() <= QCAP)
      else
      begin
         $display("Queue took more entries than the banks can hold");
         other_errs++;
      end
   endtask

   // Pop until the model and the decode slots are both empty
   task automatic drain_queue();
      int   tries;
      logic taken;
      tries      = 0;
      valid_seen = '1;
      while ((exp_q.size() != 0 || valid_seen != '0) && tries < 40)
      begin
         drive_cycle(1'b0, next_pc, pick_pop(2), 1'b0, taken);
         tries++;
      end
      assert (exp_q.size() == 0 && valid_seen == '0)
      else
      begin
         $display("Queue did not drain within 40 cycles");
         other_errs++;
      end
   endtask

   task automatic check_after_reset();
      logic taken;
      // Idle cycle against an empty model
      drive_cycle(1'b0, next_pc, 0, 1'b0, taken);
   endtask

   task automatic run_aligned_stream();
      logic taken;
      // Back to back full windows while decode takes two
      for (int w = 0; w < 3; w++)
      begin
         load_window();
         drive_cycle(1'b1, next_pc, pick_pop(2), 1'b0, taken);
         next_pc += WIN_BYTES;
      end
      drain_queue();
   endtask

   task automatic run_offset_windows();
      logic taken;
      for (int ofs = 1; ofs < `FETCH_W; ofs++)
      begin
         load_window();
         drive_cycle(1'b1, next_pc + pc_t'(ofs * 4), 0, 1'b0, taken);
         next_pc += WIN_BYTES;
      end
      drain_queue();
   endtask

   task automatic run_backpressure();
      int   n;
      int   tries;
      logic taken;
      n     = 0;
      taken = 1'b1;
      // Full windows until fetch_ready refuses one
      while (taken && n < 8)
      begin
         load_window();
         drive_cycle(1'b1, next_pc, 0, 1'b0, taken);
         if (taken)
         begin
            next_pc += WIN_BYTES;
            n++;
         end
      end
      assert (n == 4)
      else
      begin
         $display("Fetch took %0d full windows before a refusal instead of four", n);
         other_errs++;
      end
      // Refused window held against a full queue
      repeat (2) drive_cycle(1'b1, next_pc, 0, 1'b0, taken);
      tries = 0;
      taken = 1'b0;
      while (!taken && tries < 10)
      begin
         drive_cycle(1'b1, next_pc, pick_pop(2), 1'b0, taken);
         tries++;
      end
      assert (taken)
      else
      begin
         $display("Held window was never taken after decode freed space");
         other_errs++;
      end
      next_pc += WIN_BYTES;
      drain_queue();
   endtask

   task automatic run_flush();
      logic taken;
      repeat (2)
      begin
         load_window();
         drive_cycle(1'b1, next_pc, 0, 1'b0, taken);
         next_pc += WIN_BYTES;
      end
      // Push and pop in the flush cycle are both dropped
      load_window();
      drive_cycle(1'b1, next_pc, 1, 1'b1, taken);
      next_pc += WIN_BYTES;
      // Empty right after the flush
      drive_cycle(1'b0, next_pc, 0, 1'b0, taken);
      // New window alone at the head
      load_window();
      drive_cycle(1'b1, next_pc + pc_t'(8), 0, 1'b0, taken);
      next_pc += WIN_BYTES;
      drain_queue();
   endtask

   task automatic run_random_mix();
      logic pending;
      logic fv;
      logic taken;
      pc_t  pc;
      pending = 1'b0;
      fv      = 1'b0;
      pc      = next_pc;
      for (int cyc = 0; cyc < 200; cyc++)
      begin
         // A refused window stays on the port unchanged
         if (!pending)
         begin
            fv = ({$random(seed)} % 4) != 0;
            if (fv)
            begin
               load_window();
               pc      = next_pc + pc_t'(({$random(seed)} % `FETCH_W) * 4);
               next_pc += WIN_BYTES;
            end
         end
         drive_cycle(fv, pc, pick_pop({$random(seed)} % 3), 1'b0, taken);
         pending = fv & ~taken;
      end
      drain_queue();
   endtask

   initial
   begin
      seed        = 32'hd0039333;
      checks      = 0;
      mismatches  = 0;
      other_errs  = 0;
      valid_seen  = '0;
      next_pc     = 32'h0000_1000;
      rst_n       = 1'b0;
      flush       = 1'b0;
      fetch_valid = 1'b0;
      fetch_pc    = '0;
      id_pop_cnt  = '0;
      for (int i = 0; i < `FETCH_W; i++)
      begin
         fetch_ins[i]     = '0;
         fetch_exc[i]     = '0;
         fetch_bpu_upd[i] = '0;
      end
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;
      check_after_reset();
      run_aligned_stream();
      run_offset_windows();
      run_backpressure();
      run_flush();
      run_random_mix();
      $display("Checks %0d, mismatches %0d, other errors %0d", checks, mismatches,
               other_errs);
      if (mismatches == 0 && other_errs == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

endmodule

//--- insn_queue_top.f
+incdir+hdl
hdl/fetch_pkg.sv
hdl/bank_pkg.sv
hdl/fifo_fwft.sv
hdl/fetch_window_align.sv
hdl/prefetch_buf.sv
hdl/insn_queue_top.sv
tests/tb_insn_queue.sv

//--- Makefile
# Verilator simulation of the instruction queue

LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal \
		-f insn_queue_top.f --top-module tb_insn_queue \
		-Mdir obj_dir -o vsim
	./obj_dir/vsim | tee $(LOG)
	grep -q ">>> PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
